//--- design/dbg_noc_pkg.sv
package dbg_noc_pkg;

   // Flit content and type widths
   localparam int flit_content_w = 16;
   localparam int flit_type_w = 2;

   // Flit kind, carried in the top bits of every flit
   typedef enum logic [flit_type_w-1:0] {
      flit_payload = 2'd0,
      flit_header  = 2'd1,
      flit_last    = 2'd2,
      flit_single  = 2'd3
   } flit_type_e;

   // 18-bit flit, type above content
   typedef struct packed {
      flit_type_e                 ftype;
      logic [flit_content_w-1:0] content;
   } flit_t;

   // Virtual channel count of the debug network
   localparam int default_vchannels = 3;

   // Channel used for traffic coming from the host
   localparam int default_inject_vc = 0;

endpackage

//--- design/fifo_link_pkg.sv
package fifo_link_pkg;

   // Host FIFO word width
   localparam int fifo_word_w = 16;

   // Longest packet in flits, in either direction
   localparam int max_pkt_len = 16;

   // Length counter must hold max_pkt_len itself
   localparam int len_w = 5;

   // Index into a one-packet buffer
   localparam int addr_w = 4;

   typedef logic [len_w-1:0] pkt_len_t;

endpackage

//--- design/word_counter.sv
module word_counter import fifo_link_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     load,
   input  pkt_len_t load_value,
   input  logic     step,
   output pkt_len_t count,
   output logic     at_last,
   output logic     busy
);

   // Words still to go in the current packet
   pkt_len_t count_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         count_q <= '0;
      end else if (load) begin
         // Load wins over step
         count_q <= load_value;
      end else if (step && (count_q != '0)) begin
         count_q <= count_q - 1'b1;
      end
   end

   assign count = count_q;

   // One word left means the next step is the final word
   assign at_last = (count_q == pkt_len_t'(1));
   assign busy    = (count_q != '0);

endmodule

//--- design/packet_store.sv
module packet_store import dbg_noc_pkg::*; import fifo_link_pkg::*; (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      wr_en,
   input  logic [flit_content_w-1:0] wr_content,
   input  logic                      rd_en,
   output logic [flit_content_w-1:0] rd_content,
   output pkt_len_t                  fill,
   input  logic                      clear
);

   // Content words of one packet
   logic [flit_content_w-1:0] mem [max_pkt_len];

   // Pointers count words, not wrap
   pkt_len_t wr_ptr_q;
   pkt_len_t rd_ptr_q;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr_q[addr_w-1:0]] <= wr_content;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else if (clear) begin
         // Packet fully sent, rewind both
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (rd_en) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   // Asynchronous read, stable while the pointer holds
   assign rd_content = mem[rd_ptr_q[addr_w-1:0]];

   // Words written so far equal the packet length
   assign fill = wr_ptr_q;

endmodule

//--- design/vc_serializer.sv
module vc_serializer import dbg_noc_pkg::*; #(
   parameter int vchannels = default_vchannels
) (
   input  logic                 clk,
   input  logic                 reset,
   input  flit_t                mvc_flit,
   input  logic [vchannels-1:0] mvc_valid,
   output logic [vchannels-1:0] mvc_ready,
   output flit_t                ser_flit,
   output logic                 ser_valid,
   input  logic                 ser_ready
);

   // Grant index width of at least one bit
   localparam int sel_w = (vchannels > 1) ? $clog2(vchannels) : 1;

   typedef logic [sel_w-1:0] sel_t;

   // Round-robin pointer that holds the locked channel while locked
   sel_t grant_q;
   logic locked_q;

   sel_t arb_sel;
   logic arb_hit;
   sel_t sel;
   sel_t sel_next;
   logic ser_xfer;

   // Search for a requester starting at the pointer
   always_comb begin
      int idx;
      arb_sel = grant_q;
      arb_hit = 1'b0;
      for (int i = 0; i < vchannels; i++) begin
         idx = (int'(grant_q) + i) % vchannels;
         if (!arb_hit && mvc_valid[idx]) begin
            arb_hit = 1'b1;
            arb_sel = sel_t'(idx);
         end
      end
   end

   // Locked channel keeps the path until its packet ends
   assign sel = locked_q ? grant_q : arb_sel;

   // Data path is pure muxing with zero latency
   assign ser_flit  = mvc_flit;
   assign ser_valid = locked_q ? mvc_valid[sel] : arb_hit;
   assign ser_xfer  = ser_valid && ser_ready;

   // Only the granted channel sees ready
   always_comb begin
      mvc_ready = '0;
      if (ser_valid) begin
         mvc_ready[sel] = ser_ready;
      end
   end

   // Channel after the one being released
   assign sel_next = (sel == sel_t'(vchannels - 1)) ? '0 : sel + 1'b1;

   always_ff @(posedge clk) begin
      if (reset) begin
         grant_q  <= '0;
         locked_q <= 1'b0;
      end else if (ser_xfer) begin
         case (mvc_flit.ftype)
            flit_header: begin
               locked_q <= 1'b1;
               grant_q  <= sel;
            end
            flit_last, flit_single: begin
               // Release and move priority on
               locked_q <= 1'b0;
               grant_q  <= sel_next;
            end
            default: begin
               // Payload keeps the current grant
            end
         endcase
      end
   end

endmodule

//--- design/noc_to_fifo.sv
module noc_to_fifo import dbg_noc_pkg::*; import fifo_link_pkg::*; (
   input  logic                   clk,
   input  logic                   reset,
   input  flit_t                  in_flit,
   input  logic                   in_valid,
   output logic                   in_ready,
   output logic [fifo_word_w-1:0] out_data,
   output logic                   out_valid,
   input  logic                   out_ready
);

   typedef enum logic [1:0] {
      st_collect,
      st_send_len,
      st_send_data
   } state_e;

   state_e state_q;

   logic in_xfer;
   logic out_xfer;
   logic pkt_end;

   logic [flit_content_w-1:0] rd_content;
   pkt_len_t fill;
   logic store_rd;
   logic store_clear;
   logic cnt_load;
   logic cnt_step;
   logic at_last;

   // Input accepted only while collecting
   assign in_ready = (state_q == st_collect);
   assign in_xfer  = in_valid && in_ready;

   // Last or single closes the packet
   assign pkt_end = (in_flit.ftype == flit_last) || (in_flit.ftype == flit_single);

   assign out_valid = (state_q != st_collect);
   assign out_xfer  = out_valid && out_ready;

   // Length word first, then stored contents
   assign out_data = (state_q == st_send_len) ? fifo_word_w'(fill) : rd_content;

   // Counter armed with the length as it goes out
   assign cnt_load    = out_xfer && (state_q == st_send_len);
   assign cnt_step    = out_xfer && (state_q == st_send_data);
   assign store_rd    = cnt_step;
   assign store_clear = cnt_step && at_last;

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q <= st_collect;
      end else begin
         case (state_q)
            st_collect: begin
               if (in_xfer && pkt_end) begin
                  state_q <= st_send_len;
               end
            end
            st_send_len: begin
               if (out_xfer) begin
                  state_q <= st_send_data;
               end
            end
            st_send_data: begin
               // Back to collecting once the final word is taken
               if (cnt_step && at_last) begin
                  state_q <= st_collect;
               end
            end
            default: state_q <= st_collect;
         endcase
      end
   end

   packet_store u_store (
      .clk       (clk),
      .reset     (reset),
      .wr_en     (in_xfer),
      .wr_content(in_flit.content),
      .rd_en     (store_rd),
      .rd_content(rd_content),
      .fill      (fill),
      .clear     (store_clear)
   );

   word_counter u_counter (
      .clk       (clk),
      .reset     (reset),
      .load      (cnt_load),
      .load_value(fill),
      .step      (cnt_step),
      .count     (),
      .at_last   (at_last),
      .busy      ()
   );

endmodule

//--- design/fifo_to_noc.sv
module fifo_to_noc import dbg_noc_pkg::*; import fifo_link_pkg::*; (
   input  logic                   clk,
   input  logic                   reset,
   input  logic [fifo_word_w-1:0] in_data,
   input  logic                   in_valid,
   output logic                   in_ready,
   output flit_t                  out_flit,
   output logic                   out_valid,
   input  logic                   out_ready
);

   // One-flit output register
   flit_t out_flit_q;
   logic  out_valid_q;

   // Goes high one cycle after reset ends
   logic started_q;

   // Next content word opens the packet
   logic first_q;

   logic       in_xfer;
   logic       is_content;
   logic       at_last;
   logic       busy;
   flit_type_e next_type;

   assign in_ready   = started_q && (!out_valid_q || out_ready);
   assign in_xfer    = in_valid && in_ready;

   // Idle counter means the word is a length
   assign is_content = busy;

   always_comb begin
      if (first_q && at_last) begin
         next_type = flit_single;
      end else if (first_q) begin
         next_type = flit_header;
      end else if (at_last) begin
         next_type = flit_last;
      end else begin
         next_type = flit_payload;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         started_q   <= 1'b0;
         out_valid_q <= 1'b0;
         first_q     <= 1'b0;
      end else begin
         started_q <= 1'b1;
         if (in_xfer && is_content) begin
            out_valid_q <= 1'b1;
            first_q     <= 1'b0;
         end else begin
            if (out_ready) begin
               out_valid_q <= 1'b0;
            end
            // A zero length leaves the counter idle
            if (in_xfer) begin
               first_q <= 1'b1;
            end
         end
      end
   end

   // Payload register, no reset
   always_ff @(posedge clk) begin
      if (in_xfer && is_content) begin
         out_flit_q.ftype   <= next_type;
         out_flit_q.content <= in_data;
      end
   end

   assign out_flit  = out_flit_q;
   assign out_valid = out_valid_q;

   word_counter u_counter (
      .clk       (clk),
      .reset     (reset),
      .load      (in_xfer && !is_content),
      .load_value(in_data[len_w-1:0]),
      .step      (in_xfer && is_content),
      .count     (),
      .at_last   (at_last),
      .busy      (busy)
   );

endmodule

//--- design/fifo_dbg_if.sv
module fifo_dbg_if import dbg_noc_pkg::*; import fifo_link_pkg::*; #(
   parameter int vchannels = default_vchannels,
   parameter int inject_vc = default_inject_vc
) (
   input  logic                   clk,
   input  logic                   reset,

   // Host FIFO link
   output logic                   fifo_out_valid,
   input  logic                   fifo_out_ready,
   output logic [fifo_word_w-1:0] fifo_out_data,
   input  logic                   fifo_in_valid,
   output logic                   fifo_in_ready,
   input  logic [fifo_word_w-1:0] fifo_in_data,

   // Debug NoC link
   output flit_t                  dbgnoc_out_flit,
   output logic [vchannels-1:0]   dbgnoc_out_valid,
   input  logic [vchannels-1:0]   dbgnoc_out_ready,
   input  flit_t                  dbgnoc_in_flit,
   input  logic [vchannels-1:0]   dbgnoc_in_valid,
   output logic [vchannels-1:0]   dbgnoc_in_ready
);

   // Serialized NoC to host stream
   flit_t ser_flit;
   logic  ser_valid;
   logic  ser_ready;

   // Host to NoC stream before channel mapping
   flit_t inj_flit;
   logic  inj_valid;
   logic  inj_ready;

   // All incoming channels merged packet by packet
   vc_serializer #(
      .vchannels(vchannels)
   ) u_serializer (
      .clk      (clk),
      .reset    (reset),
      .mvc_flit (dbgnoc_in_flit),
      .mvc_valid(dbgnoc_in_valid),
      .mvc_ready(dbgnoc_in_ready),
      .ser_flit (ser_flit),
      .ser_valid(ser_valid),
      .ser_ready(ser_ready)
   );

   noc_to_fifo u_noc_to_fifo (
      .clk      (clk),
      .reset    (reset),
      .in_flit  (ser_flit),
      .in_valid (ser_valid),
      .in_ready (ser_ready),
      .out_data (fifo_out_data),
      .out_valid(fifo_out_valid),
      .out_ready(fifo_out_ready)
   );

   fifo_to_noc u_fifo_to_noc (
      .clk      (clk),
      .reset    (reset),
      .in_data  (fifo_in_data),
      .in_valid (fifo_in_valid),
      .in_ready (fifo_in_ready),
      .out_flit (inj_flit),
      .out_valid(inj_valid),
      .out_ready(inj_ready)
   );

   // Host traffic goes out on one fixed channel
   assign dbgnoc_out_flit = inj_flit;
   assign inj_ready       = dbgnoc_out_ready[inject_vc];

   always_comb begin
      dbgnoc_out_valid            = '0;
      dbgnoc_out_valid[inject_vc] = inj_valid;
   end

endmodule

//--- dv/fifo_dbg_if_props.sv
module fifo_dbg_if_props import dbg_noc_pkg::*; import fifo_link_pkg::*; #(
   parameter int vchannels = default_vchannels,
   parameter int inject_vc = default_inject_vc
) (
   input logic                   clk,
   input logic                   reset,
   input logic                   fifo_out_valid,
   input logic                   fifo_out_ready,
   input logic [fifo_word_w-1:0] fifo_out_data,
   input logic                   fifo_in_ready,
   input flit_t                  dbgnoc_out_flit,
   input logic [vchannels-1:0]   dbgnoc_out_valid,
   input logic [vchannels-1:0]   dbgnoc_out_ready,
   input flit_t                  dbgnoc_in_flit,
   input logic [vchannels-1:0]   dbgnoc_in_valid,
   input logic [vchannels-1:0]   dbgnoc_in_ready
);

   timeunit 1ns;
   timeprecision 100ps;

   // Flits taken so far in the packet entering the store
   pkt_len_t             in_count;
   logic                 in_xfer;
   logic                 in_end;
   logic [vchannels-1:0] other_valid;

   assign in_xfer = |(dbgnoc_in_valid & dbgnoc_in_ready);
   assign in_end  = (dbgnoc_in_flit.ftype == flit_last) || (dbgnoc_in_flit.ftype == flit_single);

   always_ff @(posedge clk) begin
      if (reset) begin
         in_count <= '0;
      end else if (in_xfer) begin
         in_count <= in_end ? '0 : in_count + pkt_len_t'(1);
      end
   end

   // Valid bits on channels other than inject
   always_comb begin
      other_valid            = dbgnoc_out_valid;
      other_valid[inject_vc] = 1'b0;
   end

   fifo_out_hold: assert property (@(posedge clk) disable iff (reset)
      fifo_out_valid && !fifo_out_ready |=> fifo_out_valid && $stable(fifo_out_data))
      else $error("fifo_out valid or data changed before ready");

   // Host side opens exactly one cycle after reset ends
   fifo_in_start: assert property (@(posedge clk)
      $fell(reset) |=> fifo_in_ready && !$past(fifo_in_ready))
      else $error("fifo_in_ready not raised one cycle after reset");

   noc_out_hold: assert property (@(posedge clk) disable iff (reset)
      dbgnoc_out_valid[inject_vc] && !dbgnoc_out_ready[inject_vc]
      |=> dbgnoc_out_valid[inject_vc] && $stable(dbgnoc_out_flit))
      else $error("dbgnoc_out valid or flit changed before ready");

   // Host traffic only ever on the inject channel
   inject_only: assert property (@(posedge clk) disable iff (reset) other_valid == '0)
      else $error("dbgnoc_out valid raised off the inject channel");

   pkt_len_max: assert property (@(posedge clk) disable iff (reset)
      in_xfer |-> in_count < max_pkt_len)
      else $error("incoming packet longer than max_pkt_len");

endmodule

bind fifo_dbg_if fifo_dbg_if_props #(
   .vchannels(vchannels),
   .inject_vc(inject_vc)
) props0 (.*);

//--- dv/tb_fifo_dbg_if.sv
module tb_fifo_dbg_if import dbg_noc_pkg::*; import fifo_link_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int vchannels = default_vchannels;
   localparam int inject_vc = default_inject_vc;

   // Channel used by the single-channel phase
   localparam int solo_vc = vchannels - 1;

   // Watchdog allowance per stimulus word
   localparam int cycles_per_word = 40;

   typedef logic [fifo_word_w-1:0] word_q_t [$];

   logic                   clk;
   logic                   reset;
   logic                   fifo_out_valid;
   logic                   fifo_out_ready;
   logic [fifo_word_w-1:0] fifo_out_data;
   logic                   fifo_in_valid;
   logic                   fifo_in_ready;
   logic [fifo_word_w-1:0] fifo_in_data;
   flit_t                  dbgnoc_out_flit;
   logic [vchannels-1:0]   dbgnoc_out_valid;
   logic [vchannels-1:0]   dbgnoc_out_ready;
   flit_t                  dbgnoc_in_flit;
   logic [vchannels-1:0]   dbgnoc_in_valid;
   logic [vchannels-1:0]   dbgnoc_in_ready;

   int   seed = 32'hebb4_4949;
   int   host_seed;
   int   noc_seed;
   int   rdy_seed;
   int   budget = 100;
   bit   verdict = 1'b0;
   logic throttle = 1'b0;

   // Host words still to send, flits expected on the inject channel
   word_q_t host_words;
   flit_t   exp_flits [$];
   logic    host_taken;

   // Per channel flits to offer and host words expected back
   flit_t                  ch_flits [vchannels][$];
   logic [fifo_word_w-1:0] exp_rx [vchannels][$];
   flit_t                  ch_head [vchannels];
   logic [vchannels-1:0]   ch_valid;
   logic [vchannels-1:0]   ch_taken;

   // Words of the packet now arriving at the host
   word_q_t rx_words;

   fifo_dbg_if dut0 (
      .clk             (clk),
      .reset           (reset),
      .fifo_out_valid  (fifo_out_valid),
      .fifo_out_ready  (fifo_out_ready),
      .fifo_out_data   (fifo_out_data),
      .fifo_in_valid   (fifo_in_valid),
      .fifo_in_ready   (fifo_in_ready),
      .fifo_in_data    (fifo_in_data),
      .dbgnoc_out_flit (dbgnoc_out_flit),
      .dbgnoc_out_valid(dbgnoc_out_valid),
      .dbgnoc_out_ready(dbgnoc_out_ready),
      .dbgnoc_in_flit  (dbgnoc_in_flit),
      .dbgnoc_in_valid (dbgnoc_in_valid),
      .dbgnoc_in_ready (dbgnoc_in_ready)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Expected type of flit idx in a packet of len flits
   function automatic flit_type_e flit_types_for(input int len, input int idx);
      if (len == 1) return flit_single;
      if (idx == 0) return flit_header;
      if (idx == len - 1) return flit_last;
      return flit_payload;
   endfunction

   // Length word followed by contents in order
   function automatic word_q_t expected_words(input word_q_t content);
      word_q_t words;
      words.push_back(fifo_word_w'(content.size()));
      foreach (content[i]) words.push_back(content[i]);
      return words;
   endfunction

   // Packet length drawn from 1 to max_pkt_len
   function automatic int random_len();
      return 1 + int'($unsigned($random(seed)) % max_pkt_len);
   endfunction

   task automatic report_error(input string msg);
      verdict = 1'b1;
      $display("[ERROR] %0t ns: %s", $time, msg);
      $display("Verification failed");
      $fatal(1, "stopped at first mismatch");
   endtask

   task automatic add_host_packet(input int len);
      flit_t  f;
      host_words.push_back(fifo_word_w'(len));
      for (int i = 0; i < len; i++) begin
         f.ftype   = flit_types_for(len, i);
         f.content = flit_content_w'($random(seed));
         host_words.push_back(f.content);
         exp_flits.push_back(f);
      end
      budget += (len + 1) * cycles_per_word;
   endtask

   task automatic add_noc_packet(input int c, input int len);
      flit_t   f;
      word_q_t content;
      word_q_t words;
      for (int i = 0; i < len; i++) begin
         f.ftype   = flit_types_for(len, i);
         f.content = flit_content_w'($random(seed));
         content.push_back(f.content);
         ch_flits[c].push_back(f);
      end
      words = expected_words(content);
      foreach (words[i]) exp_rx[c].push_back(words[i]);
      budget += len * cycles_per_word;
   endtask

   function automatic bit drained();
      if (host_words.size() != 0 || exp_flits.size() != 0 || rx_words.size() != 0) return 1'b0;
      for (int c = 0; c < vchannels; c++) begin
         if (ch_flits[c].size() != 0 || exp_rx[c].size() != 0) return 1'b0;
      end
      return 1'b1;
   endfunction

   task automatic wait_drained();
      do @(negedge clk); while (!drained());
      repeat (4) @(negedge clk);
   endtask

   // Host side of the FIFO link holding valid until taken
   initial begin : host_driver
      fifo_in_valid = 1'b0;
      fifo_in_data  = '0;
      host_taken    = 1'b0;
      forever begin
         @(negedge clk);
         if (host_taken) begin
            void'(host_words.pop_front());
            fifo_in_valid = 1'b0;
         end
         if (!fifo_in_valid && host_words.size() != 0 &&
             (!throttle || (($random(host_seed) & 3) != 0))) begin
            fifo_in_valid = 1'b1;
            fifo_in_data  = host_words[0];
         end
         @(posedge clk);
         host_taken = fifo_in_valid && fifo_in_ready;
      end
   end

   // Network side with one flit source per channel
   initial begin : noc_driver
      ch_valid = '0;
      ch_taken = '0;
      for (int c = 0; c < vchannels; c++) ch_head[c] = '0;
      forever begin
         @(negedge clk);
         for (int c = 0; c < vchannels; c++) begin
            if (ch_taken[c]) begin
               void'(ch_flits[c].pop_front());
               ch_valid[c] = 1'b0;
            end
            if (!ch_valid[c] && ch_flits[c].size() != 0 &&
                (!throttle || (($random(noc_seed) & 3) != 0))) begin
               ch_valid[c] = 1'b1;
               ch_head[c]  = ch_flits[c][0];
            end
         end
         @(posedge clk);
         ch_taken = ch_valid & dbgnoc_in_ready;
      end
   end

   assign dbgnoc_in_valid = ch_valid;

   // Shared network flit bus carrying the granted channel
   always_comb begin
      dbgnoc_in_flit = '0;
      for (int c = 0; c < vchannels; c++) begin
         if (dbgnoc_in_ready[c]) dbgnoc_in_flit = ch_head[c];
      end
   end

   // Sink readies go randomly low when throttled
   initial begin : ready_driver
      fifo_out_ready   = 1'b0;
      dbgnoc_out_ready = '0;
      forever begin
         @(negedge clk);
         fifo_out_ready = !throttle || (($random(rdy_seed) & 3) != 0);
         for (int c = 0; c < vchannels; c++) begin
            dbgnoc_out_ready[c] = !throttle || (($random(rdy_seed) & 3) != 0);
         end
      end
   end

   // Every flit on the inject channel against the host order
   always @(posedge clk) begin : flit_compare
      if (!reset && dbgnoc_out_valid[inject_vc] && dbgnoc_out_ready[inject_vc]) begin
         assert (exp_flits.size() != 0)
            else report_error($sformatf("unexpected flit %h", dbgnoc_out_flit));
         assert (dbgnoc_out_flit == exp_flits[0])
            else report_error($sformatf("flit got %h expected %h", dbgnoc_out_flit,
                                        exp_flits[0]));
         void'(exp_flits.pop_front());
      end
   end

   function automatic bit head_matches(input int c);
      if (exp_rx[c].size() < rx_words.size()) return 1'b0;
      foreach (rx_words[i]) begin
         if (exp_rx[c][i] != rx_words[i]) return 1'b0;
      end
      return 1'b1;
   endfunction

   // Whole packet must equal the oldest packet of one channel
   task automatic match_packet();
      int hit = -1;
      for (int c = 0; c < vchannels; c++) begin
         if (hit < 0 && head_matches(c)) hit = c;
      end
      assert (hit >= 0)
         else report_error($sformatf("packet of %0d words matches no channel",
                                     rx_words[0]));
      repeat (rx_words.size()) void'(exp_rx[hit].pop_front());
   endtask

   always @(posedge clk) begin : word_compare
      if (!reset && fifo_out_valid && fifo_out_ready) begin
         rx_words.push_back(fifo_out_data);
         if (rx_words.size() == 1) begin
            assert (rx_words[0] >= 1 && rx_words[0] <= max_pkt_len)
               else report_error($sformatf("length word %0d out of range", rx_words[0]));
         end
         if (rx_words.size() == int'(rx_words[0]) + 1) begin
            match_packet();
            rx_words.delete();
         end
      end
   end

   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < budget) begin
         @(posedge clk);
         cycles++;
      end
      verdict = 1'b1;
      $display("Timeout after %0d cycles with traffic still pending", cycles);
      $display("Verification failed");
      $fatal(1, "watchdog expired");
   end

   initial begin : main
      reset     = 1'b1;
      host_seed = seed ^ 32'h0000_0101;
      noc_seed  = seed ^ 32'h0000_0202;
      rdy_seed  = seed ^ 32'h0000_0303;
      repeat (10) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      assert (!fifo_out_valid && dbgnoc_out_valid == '0 && dbgnoc_in_ready == '0)
         else report_error("handshake outputs active after reset");

      // Host packets and one busy NoC channel
      add_host_packet(1);
      add_host_packet(max_pkt_len);
      repeat (12) add_host_packet(random_len());
      add_noc_packet(solo_vc, 1);
      add_noc_packet(solo_vc, max_pkt_len);
      repeat (10) add_noc_packet(solo_vc, random_len());
      wait_drained();

      // All channels offered at once
      for (int k = 0; k < 6; k++) begin
         for (int c = 0; c < vchannels; c++) add_noc_packet(c, random_len());
      end
      wait_drained();

      // Random valid gaps and back-pressure in both directions
      throttle = 1'b1;
      repeat (20) add_host_packet(random_len());
      for (int k = 0; k < 6; k++) begin
         for (int c = 0; c < vchannels; c++) add_noc_packet(c, random_len());
      end
      wait_drained();
      throttle = 1'b0;
      repeat (20) @(negedge clk);

      verdict = 1'b1;
      if (drained()) begin
         $display("Verification passed");
         $finish;
      end else begin
         $display("Traffic left over at end of test");
         $display("Verification failed");
         $fatal(1, "end of test check");
      end
   end

   // Stopped by a bound assertion before any verdict
   final begin
      if (!verdict) begin
         $display("Verification failed");
      end
   end

endmodule

//--- filelist.f
design/dbg_noc_pkg.sv
design/fifo_link_pkg.sv
design/word_counter.sv
design/packet_store.sv
design/vc_serializer.sv
design/noc_to_fifo.sv
design/fifo_to_noc.sv
design/fifo_dbg_if.sv
dv/fifo_dbg_if_props.sv
dv/tb_fifo_dbg_if.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fifo_dbg_if testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
   --top-module tb_fifo_dbg_if \
   -f filelist.f \
   -Mdir obj_dir -o sim > build.log 2>&1
status=$?
if [ "$status" -ne 0 ]; then
   echo "Build failed with status $status, see build.log"
   exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status, see sim.log"
   exit 1
fi

if grep -qx "Verification passed" sim.log; then
   echo "PASS"
   exit 0
fi
echo "FAIL, see sim.log"
exit 1
